//--- hw/hart_pkg.sv
package hart_pkg;

  localparam int XLEN   = 32;  // data and address width
  localparam int REG_AW = 5;   // register number width

  // ebreak is the only system instruction kept and it marks the end of a program
  localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B  // hands operand b straight through for lui
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4  // return address of jal
  } wb_sel_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   inst;
    alu_op_e           alu_op;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;        // rs2 or the immediate, already chosen in decode
    logic [XLEN-1:0]   store_data;
    logic [XLEN-1:0]   imm;         // branch or jal offset
    logic [REG_AW-1:0] rd;          // zero when nothing is written
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              is_branch;
    logic              branch_ne;
    logic              is_jal;
    wb_sel_e           wb_sel;
    logic              halt;
  } id_ex_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   inst;
    logic [XLEN-1:0]   alu_result;  // doubles as the data address for lw and sw
    logic [XLEN-1:0]   store_data;
    logic [REG_AW-1:0] rd;
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    wb_sel_e           wb_sel;
    logic [XLEN-1:0]   next_pc;
    logic              halt;
  } ex_mem_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   inst;
    logic [REG_AW-1:0] rd;
    logic              reg_write;
    logic [XLEN-1:0]   wdata;
    logic [XLEN-1:0]   next_pc;
    logic              halt;
  } mem_wb_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;  // always word aligned
    logic            ren;
    logic            wen;
    logic [XLEN-1:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   inst;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   next_pc;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rd_wdata;
    logic              halt;
  } retire_t;

endpackage

//--- hw/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic [hart_pkg::REG_AW-1:0] i_rs1,
  input  logic [hart_pkg::REG_AW-1:0] i_rs2,
  output logic [hart_pkg::XLEN-1:0]   o_rs1_data,
  output logic [hart_pkg::XLEN-1:0]   o_rs2_data,
  input  logic                        i_wen,
  input  logic [hart_pkg::REG_AW-1:0] i_waddr,
  input  logic [hart_pkg::XLEN-1:0]   i_wdata
);
  import hart_pkg::*;

  logic [XLEN-1:0] regs [0:31];  // entry 0 is never written
  logic            wr_en;

  assign wr_en = i_wen && !i_rst && (i_waddr != '0);

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // a write in the same cycle is passed straight to the reader
  assign o_rs1_data = (i_rs1 == '0) ? '0 :
                      (wr_en && i_waddr == i_rs1) ? i_wdata : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 :
                      (wr_en && i_waddr == i_rs2) ? i_wdata : regs[i_rs2];

endmodule

//--- hw/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
  input  logic [hart_pkg::REG_AW-1:0] i_rs1,
  input  logic [hart_pkg::REG_AW-1:0] i_rs2,
  input  logic                        i_uses_rs1,
  input  logic                        i_uses_rs2,
  input  logic [hart_pkg::REG_AW-1:0] i_ex_rd,      // instruction now in execute
  input  logic                        i_ex_write,
  input  logic [hart_pkg::REG_AW-1:0] i_mem_rd,     // instruction now in memory
  input  logic                        i_mem_write,
  output logic                        o_stall
);

  logic rs1_hit;
  logic rs2_hit;

  // writeback is not checked because the register file bypasses that write
  assign rs1_hit = i_uses_rs1 && (i_rs1 != '0) &&
                   ((i_ex_write && i_ex_rd == i_rs1) || (i_mem_write && i_mem_rd == i_rs1));
  assign rs2_hit = i_uses_rs2 && (i_rs2 != '0) &&
                   ((i_ex_write && i_ex_rd == i_rs2) || (i_mem_write && i_mem_rd == i_rs2));

  assign o_stall = rs1_hit || rs2_hit;  // at most two cycles per producer

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage #(
  parameter logic [hart_pkg::XLEN-1:0] RESET_ADDR = '0
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_stall,           // hold pc and IF/ID
  input  logic                      i_redirect_valid,  // resolved in execute
  input  logic [hart_pkg::XLEN-1:0] i_redirect_pc,
  input  logic [hart_pkg::XLEN-1:0] i_imem_rdata,
  output logic [hart_pkg::XLEN-1:0] o_imem_raddr,
  output hart_pkg::if_id_t          o_if_id
);
  import hart_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;
  if_id_t          if_id_q;

  // a redirect beats a stall since the stalled instruction is being flushed anyway
  always_comb begin
    if (i_redirect_valid) begin
      pc_d = i_redirect_pc;
    end else if (i_stall) begin
      pc_d = pc_q;
    end else begin
      pc_d = pc_q + XLEN'(4);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= RESET_ADDR;
    end else begin
      pc_q <= pc_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall || i_redirect_valid) begin
      if_id_q.pc   <= pc_q;
      if_id_q.inst <= i_imem_rdata;  // the memory answers in the same cycle
    end
    if (i_rst || i_redirect_valid) begin
      if_id_q.valid <= 1'b0;  // the word behind a taken branch is dropped
    end else if (!i_stall) begin
      if_id_q.valid <= 1'b1;
    end
  end

  assign o_imem_raddr = pc_q;
  assign o_if_id      = if_id_q;

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  hart_pkg::if_id_t            i_if_id,
  input  logic                        i_stall,  // turns this slot into a bubble
  input  logic                        i_flush,  // redirect from execute
  input  hart_pkg::mem_wb_t           i_wb,     // writeback into the register file
  output logic [hart_pkg::REG_AW-1:0] o_rs1,
  output logic [hart_pkg::REG_AW-1:0] o_rs2,
  output logic                        o_uses_rs1,
  output logic                        o_uses_rs2,
  output hart_pkg::id_ex_t            o_id_ex
);
  import hart_pkg::*;

  logic [XLEN-1:0] inst;
  logic [2:0]      funct3;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_u;
  logic            uses_rs1;
  logic            uses_rs2;
  logic            writes_rd;
  id_ex_t          id_ex_d;
  id_ex_t          id_ex_q;

  assign inst   = i_if_id.inst;
  assign funct3 = inst[14:12];
  assign o_rs1  = inst[19:15];
  assign o_rs2  = inst[24:20];

  reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1      (o_rs1),
    .i_rs2      (o_rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wen      (i_wb.valid && i_wb.reg_write),  // bubbles never write
    .i_waddr    (i_wb.rd),
    .i_wdata    (i_wb.wdata)
  );

  // sign extended immediates for each encoding format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    id_ex_d            = '0;  // anything not recognised falls out as a no-op
    id_ex_d.valid      = i_if_id.valid;
    id_ex_d.pc         = i_if_id.pc;
    id_ex_d.inst       = inst;
    id_ex_d.alu_op     = ALU_ADD;
    id_ex_d.op_a       = rs1_data;
    id_ex_d.op_b       = rs2_data;
    id_ex_d.store_data = rs2_data;
    id_ex_d.wb_sel     = WB_ALU;
    uses_rs1           = 1'b0;
    uses_rs2           = 1'b0;
    writes_rd          = 1'b0;
    case (opcode_e'(inst[6:0]))
      OPC_OP: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        writes_rd = 1'b1;
        case (funct3)
          3'b000: id_ex_d.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
          3'b001: id_ex_d.alu_op = ALU_SLL;
          3'b010: id_ex_d.alu_op = ALU_SLT;
          3'b100: id_ex_d.alu_op = ALU_XOR;
          3'b101: begin
            id_ex_d.alu_op = ALU_SRL;
            writes_rd      = !inst[30];  // sra is not supported
          end
          3'b110: id_ex_d.alu_op = ALU_OR;
          3'b111: id_ex_d.alu_op = ALU_AND;
          default: writes_rd = 1'b0;  // sltu
        endcase
      end
      OPC_OP_IMM: begin
        uses_rs1     = 1'b1;
        writes_rd    = 1'b1;
        id_ex_d.op_b = imm_i;
        case (funct3)
          3'b000: id_ex_d.alu_op = ALU_ADD;
          3'b010: id_ex_d.alu_op = ALU_SLT;
          3'b100: id_ex_d.alu_op = ALU_XOR;
          3'b110: id_ex_d.alu_op = ALU_OR;
          3'b111: id_ex_d.alu_op = ALU_AND;
          default: writes_rd = 1'b0;  // immediate shifts and sltiu retire as no-ops
        endcase
      end
      OPC_LUI: begin
        writes_rd      = 1'b1;
        id_ex_d.alu_op = ALU_PASS_B;
        id_ex_d.op_b   = imm_u;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin  // word loads only
          uses_rs1         = 1'b1;
          writes_rd        = 1'b1;
          id_ex_d.mem_read = 1'b1;
          id_ex_d.op_b     = imm_i;
          id_ex_d.wb_sel   = WB_MEM;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          uses_rs1          = 1'b1;
          uses_rs2          = 1'b1;
          id_ex_d.mem_write = 1'b1;
          id_ex_d.op_b      = imm_s;
        end
      end
      OPC_BRANCH: begin
        if (funct3[2:1] == 2'b00) begin  // beq and bne differ only in funct3[0]
          uses_rs1          = 1'b1;
          uses_rs2          = 1'b1;
          id_ex_d.is_branch = 1'b1;
          id_ex_d.branch_ne = funct3[0];
          id_ex_d.imm       = imm_b;
        end
      end
      OPC_JAL: begin
        writes_rd      = 1'b1;
        id_ex_d.is_jal = 1'b1;
        id_ex_d.wb_sel = WB_PC4;
        id_ex_d.imm    = imm_j;
      end
      OPC_SYSTEM: id_ex_d.halt = (inst == EBREAK_INST);
      default: ;  // jalr, auipc and everything else
    endcase
    // x0 as a target counts as no write so the hazard unit never waits on it
    id_ex_d.rd        = writes_rd ? inst[11:7] : '0;
    id_ex_d.reg_write = writes_rd && (inst[11:7] != '0);
  end

  assign o_uses_rs1 = uses_rs1 && i_if_id.valid;
  assign o_uses_rs2 = uses_rs2 && i_if_id.valid;

  always_ff @(posedge i_clk) begin
    id_ex_q <= id_ex_d;
    if (i_rst || i_flush || i_stall) begin
      id_ex_q.valid <= 1'b0;  // bubble into execute
    end
  end

  assign o_id_ex = id_ex_q;

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  hart_pkg::id_ex_t            i_id_ex,
  output logic                        o_redirect_valid,
  output logic [hart_pkg::XLEN-1:0]   o_redirect_pc,
  output logic [hart_pkg::REG_AW-1:0] o_ex_rd,
  output logic                        o_ex_write,
  output hart_pkg::ex_mem_t           o_ex_mem
);
  import hart_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] next_pc;
  logic            taken;
  ex_mem_t         ex_mem_d;
  ex_mem_t         ex_mem_q;

  assign op_a = i_id_ex.op_a;
  assign op_b = i_id_ex.op_b;

  always_comb begin
    case (i_id_ex.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLL:    alu_result = op_a << op_b[4:0];  // only the low five bits shift
      ALU_SRL:    alu_result = op_a >> op_b[4:0];
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // branch operands are rs1 and rs2, so equality is checked on them directly
  assign taken    = i_id_ex.is_jal ||
                    (i_id_ex.is_branch && ((op_a == op_b) != i_id_ex.branch_ne));
  assign pc_plus4 = i_id_ex.pc + XLEN'(4);
  assign target   = i_id_ex.pc + i_id_ex.imm;
  assign next_pc  = taken ? target : pc_plus4;

  // a jump to the very next word needs no flush
  assign o_redirect_valid = i_id_ex.valid && (next_pc != pc_plus4);
  assign o_redirect_pc    = next_pc;
  assign o_ex_rd          = i_id_ex.rd;
  assign o_ex_write       = i_id_ex.valid && i_id_ex.reg_write;

  assign ex_mem_d = '{
    valid:      i_id_ex.valid,
    pc:         i_id_ex.pc,
    inst:       i_id_ex.inst,
    alu_result: alu_result,
    store_data: i_id_ex.store_data,
    rd:         i_id_ex.rd,
    reg_write:  i_id_ex.reg_write,
    mem_read:   i_id_ex.mem_read,
    mem_write:  i_id_ex.mem_write,
    wb_sel:     i_id_ex.wb_sel,
    next_pc:    next_pc,
    halt:       i_id_ex.halt
  };

  always_ff @(posedge i_clk) begin
    ex_mem_q <= ex_mem_d;
    if (i_rst) begin
      ex_mem_q.valid <= 1'b0;
    end
  end

  assign o_ex_mem = ex_mem_q;

endmodule

//--- hw/mem_wb_stage.sv
`timescale 1ns/10ps

module mem_wb_stage (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  hart_pkg::ex_mem_t           i_ex_mem,
  input  logic [hart_pkg::XLEN-1:0]   i_dmem_rdata,  // combinational read data
  output hart_pkg::dmem_req_t         o_dmem_req,
  output logic [hart_pkg::REG_AW-1:0] o_mem_rd,
  output logic                        o_mem_write,
  output hart_pkg::mem_wb_t           o_mem_wb,
  output hart_pkg::retire_t           o_retire
);
  import hart_pkg::*;

  logic [XLEN-1:0] wdata;
  mem_wb_t         mem_wb_q;

  // decode never sets both mem_read and mem_write, so ren and wen stay exclusive
  assign o_dmem_req = '{
    addr:  {i_ex_mem.alu_result[XLEN-1:2], 2'b00},
    ren:   i_ex_mem.valid && i_ex_mem.mem_read,
    wen:   i_ex_mem.valid && i_ex_mem.mem_write,
    wdata: i_ex_mem.store_data
  };

  assign o_mem_rd    = i_ex_mem.rd;
  assign o_mem_write = i_ex_mem.valid && i_ex_mem.reg_write;

  always_comb begin
    case (i_ex_mem.wb_sel)
      WB_MEM:  wdata = i_dmem_rdata;
      WB_PC4:  wdata = i_ex_mem.pc + XLEN'(4);  // jal link address
      default: wdata = i_ex_mem.alu_result;
    endcase
  end

  always_ff @(posedge i_clk) begin
    mem_wb_q.pc        <= i_ex_mem.pc;
    mem_wb_q.inst      <= i_ex_mem.inst;
    mem_wb_q.rd        <= i_ex_mem.rd;
    mem_wb_q.reg_write <= i_ex_mem.reg_write;
    mem_wb_q.wdata     <= wdata;
    mem_wb_q.next_pc   <= i_ex_mem.next_pc;
    mem_wb_q.halt      <= i_ex_mem.halt;
    mem_wb_q.valid     <= i_rst ? 1'b0 : i_ex_mem.valid;
  end

  assign o_mem_wb = mem_wb_q;

  // the retire record describes the write the register file takes this cycle
  assign o_retire = '{
    valid:    mem_wb_q.valid,
    inst:     mem_wb_q.inst,
    pc:       mem_wb_q.pc,
    next_pc:  mem_wb_q.next_pc,
    rd:       mem_wb_q.rd,
    rd_wdata: mem_wb_q.reg_write ? mem_wb_q.wdata : '0,
    halt:     mem_wb_q.halt
  };

endmodule

//--- hw/hart_top.sv
`timescale 1ns/10ps

module hart_top #(
  parameter logic [hart_pkg::XLEN-1:0] RESET_ADDR = '0  // first fetch address after reset
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  output logic [hart_pkg::XLEN-1:0] o_imem_raddr,
  input  logic [hart_pkg::XLEN-1:0] i_imem_rdata,  // combinational, same cycle
  output hart_pkg::dmem_req_t       o_dmem_req,
  input  logic [hart_pkg::XLEN-1:0] i_dmem_rdata,
  output hart_pkg::retire_t         o_retire
);
  import hart_pkg::*;

  if_id_t            if_id;
  id_ex_t            id_ex;
  ex_mem_t           ex_mem;
  mem_wb_t           mem_wb;
  logic              stall;           // decode waits for a producer to reach writeback
  logic              redirect_valid;  // taken branch or jal flushes the two younger slots
  logic [XLEN-1:0]   redirect_pc;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic              uses_rs1;
  logic              uses_rs2;
  logic [REG_AW-1:0] ex_rd;
  logic              ex_write;
  logic [REG_AW-1:0] mem_rd;
  logic              mem_write;

  fetch_stage #(
    .RESET_ADDR (RESET_ADDR)
  ) u_fetch (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_stall          (stall),
    .i_redirect_valid (redirect_valid),
    .i_redirect_pc    (redirect_pc),
    .i_imem_rdata     (i_imem_rdata),
    .o_imem_raddr     (o_imem_raddr),
    .o_if_id          (if_id)
  );

  decode_stage u_decode (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_if_id    (if_id),
    .i_stall    (stall),
    .i_flush    (redirect_valid),
    .i_wb       (mem_wb),          // register file write port
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_uses_rs1 (uses_rs1),
    .o_uses_rs2 (uses_rs2),
    .o_id_ex    (id_ex)
  );

  hazard_unit u_hazard (
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_uses_rs1  (uses_rs1),
    .i_uses_rs2  (uses_rs2),
    .i_ex_rd     (ex_rd),
    .i_ex_write  (ex_write),
    .i_mem_rd    (mem_rd),
    .i_mem_write (mem_write),
    .o_stall     (stall)
  );

  execute_stage u_execute (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_id_ex          (id_ex),
    .o_redirect_valid (redirect_valid),
    .o_redirect_pc    (redirect_pc),
    .o_ex_rd          (ex_rd),
    .o_ex_write       (ex_write),
    .o_ex_mem         (ex_mem)
  );

  mem_wb_stage u_mem_wb (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_ex_mem     (ex_mem),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_req   (o_dmem_req),
    .o_mem_rd     (mem_rd),
    .o_mem_write  (mem_write),
    .o_mem_wb     (mem_wb),
    .o_retire     (o_retire)
  );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_PERIOD  = 50,  // 100 ns clock
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  // reset is held for whole cycles and let go on a falling edge
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

//--- tests/hart_assertions.sv
`timescale 1ns/10ps

module hart_assertions (
  input logic                i_clk,
  input logic                i_rst,
  input hart_pkg::dmem_req_t i_dmem_req,
  input hart_pkg::retire_t   i_retire
);

  // a data access is either a load or a store, never both
  a_dmem_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_dmem_req.ren && i_dmem_req.wen))
    else $error("dmem read and write requested in the same cycle");

  a_retire_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    i_retire.valid |-> (i_retire.pc[1:0] == 2'b00))
    else $error("retired pc is not word aligned");

  // only forward word offsets are used, so every successor is aligned too
  a_retire_next_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    i_retire.valid |-> (i_retire.next_pc[1:0] == 2'b00))
    else $error("retired next_pc is not word aligned");

endmodule

//--- tests/hart_checker.sv
`timescale 1ns/10ps

module hart_checker #(
  parameter int NROWS = 30
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  hart_pkg::retire_t i_retire,
  input  logic [79:0]       i_row_name [NROWS],
  input  logic [31:0]       i_row_inst [NROWS],
  input  logic              i_row_flag [NROWS],   // 0 for rows a branch jumps over
  input  logic [4:0]        i_row_rd [NROWS],
  input  logic [31:0]       i_row_wdata [NROWS],
  input  logic [31:0]       i_dmem_word,          // data memory word the sw targets
  input  logic [31:0]       i_dmem_exp,
  input  logic              i_end,                // the run is over and the closing checks are due
  output logic              o_done,
  output logic              o_checked,
  output int                o_errors,
  output int                o_retired,
  output int                o_expected
);

  int   errors   = 0;
  int   retired  = 0;
  int   expected = 0;
  int   ptr      = 0;  // next table row that should retire
  logic rst_q    = 1'b1;
  logic halted   = 1'b0;
  logic checked  = 1'b0;

  task automatic compare_field(input logic [79:0] name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %0s %0s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  // outputs settle between edges so the retire record is read at the rising edge
  always @(posedge i_clk) begin
    int          nxt;
    int          k;
    logic        last_row;
    logic [31:0] exp_next;
    rst_q <= i_rst;
    if (i_rst || rst_q) begin
      if (i_retire.valid === 1'b1) begin
        errors++;
        $display("retire valid seen during reset or in the cycle after it");
      end
    end else if (i_retire.valid && !halted) begin
      while (ptr < NROWS && !i_row_flag[ptr]) ptr++;  // skipped rows never retire
      if (ptr >= NROWS) begin
        errors++;
        $display("extra retire after the last table row, pc %h", i_retire.pc);
      end else begin
        // the successor is the next row that is expected to retire
        nxt = ptr + 1;
        while (nxt < NROWS && !i_row_flag[nxt]) nxt++;
        last_row = (nxt >= NROWS);  // the program ends in ebreak, so only its row halts
        if (last_row) begin
          nxt = ptr + 1;
        end
        exp_next = 32'(nxt * 4);
        compare_field(i_row_name[ptr], "pc", 32'(ptr * 4), i_retire.pc);
        compare_field(i_row_name[ptr], "inst", i_row_inst[ptr], i_retire.inst);
        compare_field(i_row_name[ptr], "rd", 32'(i_row_rd[ptr]), 32'(i_retire.rd));
        compare_field(i_row_name[ptr], "wdata", i_row_wdata[ptr], i_retire.rd_wdata);
        compare_field(i_row_name[ptr], "next_pc", exp_next, i_retire.next_pc);
        compare_field(i_row_name[ptr], "halt", 32'(last_row), 32'(i_retire.halt));
        retired++;
        ptr++;
        halted = i_retire.halt;  // whatever follows ebreak is not part of the program
      end
    end
    if (i_end && !checked) begin
      expected = 0;
      for (k = 0; k < NROWS; k++) begin
        if (i_row_flag[k]) begin
          expected++;
        end
      end
      if (retired != expected) begin
        errors++;
        $display("%0d rows retired but %0d rows were expected", retired, expected);
      end
      compare_field("sw_lw", "dmem word", i_dmem_exp, i_dmem_word);  // store really landed
      checked = 1'b1;
    end
  end

  assign o_done     = halted;
  assign o_checked  = checked;
  assign o_errors   = errors;
  assign o_retired  = retired;
  assign o_expected = expected;

endmodule

//--- tests/hart_tb.sv
`timescale 1ns/10ps

module hart_tb;
  import hart_pkg::*;

  localparam int          NROWS       = 30;
  localparam logic [31:0] ROW_BYTES   = 32'(NROWS * 4);
  localparam logic [31:0] NOP_WORD    = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [31:0] STORE_WORD  = 32'h1234_5678;  // lui 0x12345 then ori 0x678
  localparam int          RESET_LIMIT = 20;
  localparam int          RUN_LIMIT   = 300;
  localparam int          END_LIMIT   = 10;

  logic        clk;
  logic        rst;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  dmem_req_t   dmem_req;
  logic [31:0] dmem_rdata;
  retire_t     retire;
  logic [31:0] dmem [64];
  logic [79:0] row_name [NROWS];
  logic [31:0] row_inst [NROWS];
  logic        row_flag [NROWS];
  logic [4:0]  row_rd [NROWS];
  logic [31:0] row_wdata [NROWS];
  int          nrow = 0;
  logic        end_req;
  logic        done;
  logic        checked;
  int          errors;
  int          retired;
  int          expected;
  int          cycles;
  logic        timed_out;

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] upper_op(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] load_op(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] store_op(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // offsets are byte offsets and bit 0 is dropped by the encoding
  function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_op(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_row(input logic [79:0] name, input logic [31:0] inst, input logic flag,
                         input logic [4:0] rd, input logic [31:0] wdata);
    row_name[nrow]  = name;
    row_inst[nrow]  = inst;
    row_flag[nrow]  = flag;
    row_rd[nrow]    = rd;
    row_wdata[nrow] = wdata;
    nrow++;
  endtask

  tb_clock #(.HALF_PERIOD(50), .RESET_CYCLES(5)) u_clock (.o_clk(clk), .o_rst(rst));

  hart_top #(.RESET_ADDR(32'h0000_0000)) dut0 (
    .i_clk        (clk),
    .i_rst        (rst),
    .o_imem_raddr (imem_raddr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_req   (dmem_req),
    .i_dmem_rdata (dmem_rdata),
    .o_retire     (retire)
  );

  bind hart_top hart_assertions u_assertions (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_dmem_req (o_dmem_req),
    .i_retire   (o_retire)
  );

  hart_checker #(.NROWS(NROWS)) u_checker (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_retire    (retire),
    .i_row_name  (row_name),
    .i_row_inst  (row_inst),
    .i_row_flag  (row_flag),
    .i_row_rd    (row_rd),
    .i_row_wdata (row_wdata),
    .i_dmem_word (dmem[2]),     // byte address 8
    .i_dmem_exp  (STORE_WORD),
    .i_end       (end_req),
    .o_done      (done),
    .o_checked   (checked),
    .o_errors    (errors),
    .o_retired   (retired),
    .o_expected  (expected)
  );

  // instruction memory is the table itself and returns no-ops past its end
  assign imem_rdata = (imem_raddr < ROW_BYTES) ? row_inst[imem_raddr[6:2]] : NOP_WORD;
  assign dmem_rdata = dmem_req.ren ? dmem[dmem_req.addr[7:2]] : '0;  // data only for a load

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 64; i++) begin
        dmem[i] <= {16'hd00d, 16'(i * 4)};  // each word carries its own byte address
      end
    end else if (dmem_req.wen) begin
      dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
    end
  end

  initial begin
    end_req   = 1'b0;
    timed_out = 1'b0;
    // name, instruction, retires, rd, write data
    add_row("addi_x1", imm_op(3'b000, 5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 32'd5);
    add_row("addi_neg", imm_op(3'b000, 5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, 32'hffff_fffd);
    add_row("add_stall", reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'd2);
    add_row("sub", reg_op(7'h20, 3'b000, 5'd4, 5'd2, 5'd1), 1'b1, 5'd4, 32'hffff_fff8);
    add_row("slt_neg", reg_op(7'h00, 3'b010, 5'd5, 5'd2, 5'd1), 1'b1, 5'd5, 32'd1);
    add_row("slt_pos", reg_op(7'h00, 3'b010, 5'd6, 5'd1, 5'd2), 1'b1, 5'd6, 32'd0);
    add_row("lui", upper_op(5'd7, 20'h12345), 1'b1, 5'd7, 32'h1234_5000);
    add_row("ori_dep", imm_op(3'b110, 5'd7, 5'd7, 12'h678), 1'b1, 5'd7, STORE_WORD);
    add_row("sll", reg_op(7'h00, 3'b001, 5'd8, 5'd1, 5'd1), 1'b1, 5'd8, 32'h0000_00a0);
    add_row("srl", reg_op(7'h00, 3'b101, 5'd9, 5'd7, 5'd1), 1'b1, 5'd9, 32'h0091_a2b3);
    add_row("xor", reg_op(7'h00, 3'b100, 5'd10, 5'd7, 5'd2), 1'b1, 5'd10, 32'hedcb_a985);
    add_row("andi", imm_op(3'b111, 5'd11, 5'd7, 12'h0f0), 1'b1, 5'd11, 32'h0000_0070);
    add_row("or", reg_op(7'h00, 3'b110, 5'd12, 5'd3, 5'd5), 1'b1, 5'd12, 32'd3);
    add_row("xori", imm_op(3'b100, 5'd13, 5'd1, 12'hfff), 1'b1, 5'd13, 32'hffff_fffa);
    add_row("slti", imm_op(3'b010, 5'd14, 5'd2, 12'hffe), 1'b1, 5'd14, 32'd1);
    add_row("addi_x0", imm_op(3'b000, 5'd0, 5'd1, 12'd7), 1'b1, 5'd0, 32'd0);
    add_row("sw", store_op(5'd7, 5'd0, 12'd8), 1'b1, 5'd0, 32'd0);
    add_row("lw", load_op(5'd15, 5'd0, 12'd8), 1'b1, 5'd15, STORE_WORD);
    add_row("beq_taken", branch_op(3'b000, 5'd1, 5'd1, 13'd12), 1'b1, 5'd0, 32'd0);
    add_row("skip_1", imm_op(3'b000, 5'd16, 5'd0, 12'd1), 1'b0, 5'd0, 32'd0);
    add_row("skip_2", imm_op(3'b000, 5'd16, 5'd0, 12'd2), 1'b0, 5'd0, 32'd0);
    add_row("bne_not", branch_op(3'b001, 5'd1, 5'd1, 13'd8), 1'b1, 5'd0, 32'd0);
    add_row("addi_x17", imm_op(3'b000, 5'd17, 5'd0, 12'd9), 1'b1, 5'd17, 32'd9);
    add_row("bne_taken", branch_op(3'b001, 5'd1, 5'd2, 13'd8), 1'b1, 5'd0, 32'd0);
    add_row("skip_3", imm_op(3'b000, 5'd17, 5'd0, 12'd1), 1'b0, 5'd0, 32'd0);
    add_row("jal", jal_op(5'd18, 21'd12), 1'b1, 5'd18, 32'h0000_0068);  // link is 100 + 4
    add_row("skip_4", imm_op(3'b000, 5'd19, 5'd0, 12'd1), 1'b0, 5'd0, 32'd0);
    add_row("skip_5", imm_op(3'b000, 5'd19, 5'd0, 12'd2), 1'b0, 5'd0, 32'd0);
    add_row("add_link", reg_op(7'h00, 3'b000, 5'd20, 5'd18, 5'd15), 1'b1, 5'd20, 32'h1234_56e0);
    add_row("ebreak", 32'h0010_0073, 1'b1, 5'd0, 32'd0);

    cycles = 0;
    while (rst && cycles < RESET_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (rst) begin
      timed_out = 1'b1;
      $display("reset was never released");
    end

    cycles = 0;
    while (!timed_out && !done && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!timed_out && !done) begin
      timed_out = 1'b1;
      $display("timed out waiting for ebreak to retire");
    end

    if (!timed_out) begin
      end_req = 1'b1;  // changed on the falling edge like every other input
      cycles  = 0;
      while (!checked && cycles < END_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (!checked) begin
        timed_out = 1'b1;
        $display("timed out waiting for the closing checks");
      end
    end

    $display("retired %0d of %0d expected rows, %0d errors", retired, expected, errors);
    if (!timed_out && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
hw/hart_pkg.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/hart_top.sv
tests/tb_clock.sv
tests/hart_assertions.sv
tests/hart_checker.sv
tests/hart_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module hart_tb -o hart_sim
./obj_dir/hart_sim 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
